// ==== hw/werewolf_pkg.sv ====
package werewolf_pkg;

    // ----------------------------------------------------------------------
    // Game constants
    // ----------------------------------------------------------------------
    localparam int NUM_PLAYERS     = 5;
    localparam int NUM_DEALS       = 20;   // Role table entries
    localparam int WOLF_WIN_DEATHS = 3;

    typedef logic [2:0] player_t;          // Seat code, 0..4 are players
    typedef logic [4:0] deal_t;            // Deal index into role table

    localparam player_t SKIP_CHOICE = 3'd5; // Choose nobody
    localparam player_t NO_CHOICE   = 3'd7; // Nothing pressed yet

    typedef enum logic [1:0] {
        VILLAGER = 2'd0,
        WOLF     = 2'd1,
        MEDIC    = 2'd2
    } role_t;

    // Per-seat status as seen by the tally
    typedef struct packed {
        role_t role;
        logic  alive;
    } seat_t;

    // ----------------------------------------------------------------------
    // Control states, also exported as the state code
    // ----------------------------------------------------------------------
    typedef enum logic [4:0] {
        IDLE        = 5'd0,
        DEAL        = 5'd1,   // Deal counter spinning
        STORE       = 5'd2,   // Seats latch roles
        NIGHT_START = 5'd3,
        NIGHT_CHECK = 5'd4,   // Skip dead seats
        NIGHT_TURN  = 5'd5,
        NIGHT_NEXT  = 5'd6,
        RESOLVE     = 5'd7,   // Dawn kill
        CHECK_NIGHT = 5'd8,
        DAY_VOTE    = 5'd9,
        VOTE_KILL   = 5'd10,
        CHECK_DAY   = 5'd11,
        VILLAGE_WIN = 5'd12,
        WOLF_WIN    = 5'd13
    } game_state_t;

endpackage

// ==== hw/button_input.sv ====
module button_input (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [werewolf_pkg::NUM_PLAYERS-1:0]   buttons,
    input  logic                                   skip,
    input  logic                                   pass,
    input  logic                                   choice_clear,
    output werewolf_pkg::player_t                  choice,
    output logic                                   pass_pulse
);

    logic [werewolf_pkg::NUM_PLAYERS:0] press_vec;   // Skip sits above the players
    logic [2:0]                         hits;
    werewolf_pkg::player_t              code;
    logic                               pass_q0;
    logic                               pass_q1;

    assign press_vec = {skip, buttons};

    // Encoder, bit NUM_PLAYERS lands on SKIP_CHOICE
    always_comb begin
        hits = '0;
        code = werewolf_pkg::NO_CHOICE;
        for (int i = 0; i <= werewolf_pkg::NUM_PLAYERS; i++) begin
            if (press_vec[i]) begin
                hits = hits + 3'd1;
                code = werewolf_pkg::player_t'(i);
            end
        end
        if (hits > 3'd1) code = werewolf_pkg::NO_CHOICE;  // Ambiguous press
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            choice  <= werewolf_pkg::NO_CHOICE;
            pass_q0 <= 1'b0;
            pass_q1 <= 1'b0;
        end else begin
            pass_q0 <= pass;
            pass_q1 <= pass_q0;
            if (choice_clear)
                choice <= werewolf_pkg::NO_CHOICE;
            else if (hits != 3'd0)
                choice <= code;            // Holds while nothing pressed
        end
    end

    assign pass_pulse = pass_q0 & ~pass_q1;  // Rising edge of pass

endmodule

// ==== hw/role_deal.sv ====
module role_deal (
    input  logic                                               clock,
    input  logic                                               reset,
    input  logic                                               deal_run,
    output werewolf_pkg::role_t [werewolf_pkg::NUM_PLAYERS-1:0] roles,
    output werewolf_pkg::deal_t                                deal_index
);

    werewolf_pkg::player_t wolf_pos;
    werewolf_pkg::player_t medic_pos;
    werewolf_pkg::player_t rank;

    // ----------------------------------------------------------------------
    // Deal counter, modulo NUM_DEALS
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            deal_index <= '0;
        else if (deal_run) begin
            if (deal_index == werewolf_pkg::deal_t'(werewolf_pkg::NUM_DEALS - 1))
                deal_index <= '0;                     // Wrap
            else
                deal_index <= deal_index + 5'd1;
        end
    end

    // ----------------------------------------------------------------------
    // Role table decode
    // ----------------------------------------------------------------------
    assign wolf_pos = deal_index[4:2];           // Four entries per wolf seat
    assign rank     = {1'b0, deal_index[1:0]};   // Medic rank among the others

    // Step over the wolf seat when counting
    assign medic_pos = (rank < wolf_pos) ? rank : rank + 3'd1;

    always_comb begin
        for (int i = 0; i < werewolf_pkg::NUM_PLAYERS; i++) begin
            if (werewolf_pkg::player_t'(i) == wolf_pos)
                roles[i] = werewolf_pkg::WOLF;
            else if (werewolf_pkg::player_t'(i) == medic_pos)
                roles[i] = werewolf_pkg::MEDIC;
            else
                roles[i] = werewolf_pkg::VILLAGER;
        end
    end

endmodule

// ==== hw/player_seat.sv ====
module player_seat #(
    parameter int SEAT = 0
) (
    input  logic                                               clock,
    input  logic                                               reset,
    input  werewolf_pkg::role_t [werewolf_pkg::NUM_PLAYERS-1:0] roles,
    input  logic                                               deal_load,
    input  logic [werewolf_pkg::NUM_PLAYERS-1:0]               kill_vec,
    output werewolf_pkg::seat_t                                status
);

    // New deal revives the seat; a kill only touches the alive flag
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            status.role  <= werewolf_pkg::VILLAGER;
            status.alive <= 1'b1;
        end else if (deal_load) begin
            status.role  <= roles[SEAT];      // Own column of the table
            status.alive <= 1'b1;
        end else if (kill_vec[SEAT]) begin
            status.alive <= 1'b0;
        end
    end

endmodule

// ==== hw/village_tally.sv ====
module village_tally (
    input  werewolf_pkg::seat_t [werewolf_pkg::NUM_PLAYERS-1:0] seats,
    output logic [werewolf_pkg::NUM_PLAYERS-1:0]               alive_vec,
    output logic [2:0]                                         dead_count,
    output werewolf_pkg::player_t                              wolf_seat,
    output werewolf_pkg::player_t                              medic_seat,
    output logic                                               wolf_won
);

    always_comb begin
        dead_count = '0;
        wolf_seat  = werewolf_pkg::NO_CHOICE;   // Only before a first deal
        medic_seat = werewolf_pkg::NO_CHOICE;
        for (int i = 0; i < werewolf_pkg::NUM_PLAYERS; i++) begin
            alive_vec[i] = seats[i].alive;
            if (!seats[i].alive)
                dead_count = dead_count + 3'd1;
            if (seats[i].role == werewolf_pkg::WOLF)
                wolf_seat = werewolf_pkg::player_t'(i);
            if (seats[i].role == werewolf_pkg::MEDIC)
                medic_seat = werewolf_pkg::player_t'(i);
        end
    end

    // Wolf takes the game once enough villagers are gone
    assign wolf_won = (dead_count >= 3'(werewolf_pkg::WOLF_WIN_DEATHS));

endmodule

// ==== hw/game_control.sv ====
module game_control (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 play,
    input  logic                                 pass_pulse,
    input  werewolf_pkg::player_t                choice,
    input  logic [werewolf_pkg::NUM_PLAYERS-1:0] alive_vec,
    input  werewolf_pkg::player_t                wolf_seat,
    input  werewolf_pkg::player_t                medic_seat,
    input  logic                                 wolf_won,
    input  werewolf_pkg::role_t                  roles_now,
    output logic                                 deal_run,
    output logic                                 deal_load,
    output logic [werewolf_pkg::NUM_PLAYERS-1:0] kill_vec,
    output logic                                 choice_clear,
    output werewolf_pkg::game_state_t            state,
    output werewolf_pkg::player_t                current_player,
    output logic                                 turn_active,
    output logic                                 vote_open,
    output logic                                 wolf_win,
    output logic                                 village_win
);

    werewolf_pkg::game_state_t next_state;
    werewolf_pkg::player_t     attacked;
    werewolf_pkg::player_t     protect_seat;
    werewolf_pkg::player_t     voted;
    logic                      target_alive;   // Choice is a living player
    logic                      move_legal;
    logic                      medic_alive;

    assign target_alive = (choice < 3'(werewolf_pkg::NUM_PLAYERS)) ? alive_vec[choice] : 1'b0;
    assign medic_alive  = (medic_seat < 3'(werewolf_pkg::NUM_PLAYERS)) ?
                          alive_vec[medic_seat] : 1'b0;

    // Legality of the current night move
    always_comb begin
        case (roles_now)
            werewolf_pkg::WOLF:
                move_legal = (choice == werewolf_pkg::SKIP_CHOICE) ||
                             (target_alive && choice != current_player);
            werewolf_pkg::MEDIC:
                move_legal = (choice == werewolf_pkg::SKIP_CHOICE) || target_alive;
            default:
                move_legal = (choice <= werewolf_pkg::SKIP_CHOICE);  // Villager just confirms
        endcase
    end

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            werewolf_pkg::IDLE, werewolf_pkg::WOLF_WIN, werewolf_pkg::VILLAGE_WIN:
                if (play) next_state = werewolf_pkg::DEAL;
            werewolf_pkg::DEAL:
                if (pass_pulse) next_state = werewolf_pkg::STORE;
            werewolf_pkg::STORE:       next_state = werewolf_pkg::NIGHT_START;
            werewolf_pkg::NIGHT_START: next_state = werewolf_pkg::NIGHT_CHECK;
            werewolf_pkg::NIGHT_CHECK:
                next_state = alive_vec[current_player] ? werewolf_pkg::NIGHT_TURN
                                                       : werewolf_pkg::NIGHT_NEXT;
            werewolf_pkg::NIGHT_TURN:
                if (pass_pulse && move_legal) next_state = werewolf_pkg::NIGHT_NEXT;
            werewolf_pkg::NIGHT_NEXT:
                next_state = (current_player == 3'(werewolf_pkg::NUM_PLAYERS - 1)) ?
                             werewolf_pkg::RESOLVE : werewolf_pkg::NIGHT_CHECK;
            werewolf_pkg::RESOLVE:     next_state = werewolf_pkg::CHECK_NIGHT;
            werewolf_pkg::CHECK_NIGHT:
                next_state = wolf_won ? werewolf_pkg::WOLF_WIN : werewolf_pkg::DAY_VOTE;
            werewolf_pkg::DAY_VOTE:
                if (pass_pulse && target_alive)
                    next_state = (choice == wolf_seat) ? werewolf_pkg::VILLAGE_WIN
                                                       : werewolf_pkg::VOTE_KILL;
            werewolf_pkg::VOTE_KILL:   next_state = werewolf_pkg::CHECK_DAY;
            werewolf_pkg::CHECK_DAY:
                next_state = wolf_won ? werewolf_pkg::WOLF_WIN : werewolf_pkg::NIGHT_START;
            default:                   next_state = werewolf_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= werewolf_pkg::IDLE;
            current_player <= '0;
        end else begin
            state <= next_state;
            if (state == werewolf_pkg::NIGHT_START)
                current_player <= '0;                          // Night opens at seat 0
            else if (state == werewolf_pkg::NIGHT_NEXT && next_state == werewolf_pkg::NIGHT_CHECK)
                current_player <= current_player + 3'd1;
        end
    end

    // Night picks and the vote target
    always_ff @(posedge clock) begin
        if (state == werewolf_pkg::NIGHT_START) begin
            attacked     <= werewolf_pkg::SKIP_CHOICE;
            protect_seat <= werewolf_pkg::SKIP_CHOICE;
        end else if (state == werewolf_pkg::NIGHT_TURN && pass_pulse && move_legal) begin
            if (roles_now == werewolf_pkg::WOLF)  attacked     <= choice;
            if (roles_now == werewolf_pkg::MEDIC) protect_seat <= choice;
        end
        if (state == werewolf_pkg::DAY_VOTE && pass_pulse && target_alive)
            voted <= choice;
    end

    // ----------------------------------------------------------------------
    // Moore outputs
    // ----------------------------------------------------------------------
    always_comb begin
        kill_vec = '0;
        if (state == werewolf_pkg::RESOLVE && attacked != werewolf_pkg::SKIP_CHOICE &&
            !(attacked == protect_seat && medic_alive))
            kill_vec[attacked] = 1'b1;                     // Unprotected victim
        else if (state == werewolf_pkg::VOTE_KILL)
            kill_vec[voted] = 1'b1;
    end

    assign deal_run     = (state == werewolf_pkg::DEAL);
    assign deal_load    = (state == werewolf_pkg::STORE);
    assign choice_clear = (state == werewolf_pkg::NIGHT_CHECK) ||   // Before each turn
                          (state == werewolf_pkg::CHECK_NIGHT);     // Before the vote
    assign turn_active  = (state == werewolf_pkg::NIGHT_TURN);
    assign vote_open    = (state == werewolf_pkg::DAY_VOTE);
    assign wolf_win     = (state == werewolf_pkg::WOLF_WIN);
    assign village_win  = (state == werewolf_pkg::VILLAGE_WIN);

endmodule

// ==== hw/werewolf_top.sv ====
module werewolf_top (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 play,
    input  logic                                 pass,
    input  logic                                 skip,
    input  logic [werewolf_pkg::NUM_PLAYERS-1:0] buttons,
    output werewolf_pkg::deal_t                  deal_index,
    output werewolf_pkg::player_t                current_player,
    output werewolf_pkg::role_t                  current_role,
    output logic                                 turn_active,
    output logic                                 vote_open,
    output logic [werewolf_pkg::NUM_PLAYERS-1:0] dead_vec,
    output werewolf_pkg::game_state_t            state,
    output logic                                 wolf_win,
    output logic                                 village_win
);

    werewolf_pkg::player_t                              choice;
    logic                                               pass_pulse;
    logic                                               choice_clear;
    logic                                               deal_run;
    logic                                               deal_load;
    logic [werewolf_pkg::NUM_PLAYERS-1:0]               kill_vec;
    werewolf_pkg::role_t [werewolf_pkg::NUM_PLAYERS-1:0] roles;
    werewolf_pkg::seat_t [werewolf_pkg::NUM_PLAYERS-1:0] seats;
    logic [werewolf_pkg::NUM_PLAYERS-1:0]               alive_vec;
    werewolf_pkg::player_t                              wolf_seat;
    werewolf_pkg::player_t                              medic_seat;
    logic                                               wolf_won;
    werewolf_pkg::role_t                                roles_now;

    button_input i_button_input (
        .clock, .reset, .buttons, .skip, .pass, .choice_clear, .choice, .pass_pulse
    );

    role_deal i_role_deal (.clock, .reset, .deal_run, .roles, .deal_index);

    // One seat per player
    for (genvar i = 0; i < werewolf_pkg::NUM_PLAYERS; i++) begin : g_seat
        player_seat #(.SEAT(i)) i_player_seat (
            .clock, .reset, .roles, .deal_load, .kill_vec, .status(seats[i])
        );
    end

    village_tally i_village_tally (
        .seats, .alive_vec, .dead_count(), .wolf_seat, .medic_seat, .wolf_won
    );

    game_control i_game_control (
        .clock, .reset, .play, .pass_pulse, .choice, .alive_vec, .wolf_seat, .medic_seat,
        .wolf_won, .roles_now, .deal_run, .deal_load, .kill_vec, .choice_clear, .state,
        .current_player, .turn_active, .vote_open, .wolf_win, .village_win
    );

    assign roles_now    = seats[current_player].role;   // Seat whose turn it is
    assign current_role = turn_active ? roles_now : werewolf_pkg::VILLAGER;  // Hidden off-turn
    assign dead_vec     = ~alive_vec;

endmodule

// ==== bench/werewolf_assert.sv ====
module werewolf_assert (
    input  logic                                 clock,
    input  logic                                 reset,
    input  werewolf_pkg::player_t                current_player,
    input  logic [werewolf_pkg::NUM_PLAYERS-1:0] alive_vec,
    input  logic [werewolf_pkg::NUM_PLAYERS-1:0] kill_vec,
    input  logic                                 turn_active,
    input  logic                                 wolf_win,
    input  logic                                 village_win
);

    int fail_count = 0;   // Failed assertions so far

    // ----------------------------------------------------------------------
    // Game control invariants
    // ----------------------------------------------------------------------
    // One winner, and it agrees with the number of dead seats
    single_winner: assert property (@(posedge clock) disable iff (reset)
        !(wolf_win && village_win) &&
        (!wolf_win || $countones(~alive_vec) >= werewolf_pkg::WOLF_WIN_DEATHS) &&
        (!village_win || $countones(~alive_vec) < werewolf_pkg::WOLF_WIN_DEATHS))
        else begin
            fail_count++;
            $error("win flags disagree with each other or with the dead seats");
        end

    // A skipped seat never opens a turn
    living_turn: assert property (@(posedge clock) disable iff (reset)
        turn_active |-> alive_vec[current_player])
        else begin
            fail_count++;
            $error("turn_active for dead seat %0d", current_player);
        end

    one_kill: assert property (@(posedge clock) disable iff (reset)
        $onehot0(kill_vec) && ((kill_vec & ~alive_vec) == '0))   // One living victim at most
        else begin
            fail_count++;
            $error("kill_vec has several bits set or hits a dead seat: %b", kill_vec);
        end

endmodule

bind game_control werewolf_assert i_werewolf_assert (
    .clock(clock), .reset(reset), .current_player(current_player), .alive_vec(alive_vec),
    .kill_vec(kill_vec), .turn_active(turn_active), .wolf_win(wolf_win),
    .village_win(village_win)
);

// ==== bench/werewolf_tb.sv ====
module werewolf_tb;

    logic                                 clock;
    logic                                 reset;
    logic                                 play;
    logic                                 pass;
    logic                                 skip;
    logic [werewolf_pkg::NUM_PLAYERS-1:0] buttons;
    werewolf_pkg::deal_t                  deal_index;
    werewolf_pkg::player_t                current_player;
    werewolf_pkg::role_t                  current_role;
    logic                                 turn_active;
    logic                                 vote_open;
    logic [werewolf_pkg::NUM_PLAYERS-1:0] dead_vec;
    werewolf_pkg::game_state_t            state;
    logic                                 wolf_win;
    logic                                 village_win;

    logic [19:0]                          tests [0:63];   // Kind, arg, dead_vec, winner
    logic [19:0]                          entry;
    logic [werewolf_pkg::NUM_PLAYERS-1:0] alive_m;        // Reference model seats
    logic [1:0]                           winner_m;       // {village, wolf}
    int                                   deal_k;
    int                                   deal_m;         // Predicted deal counter
    int                                   turn_seat;      // 5 once the night is over
    int                                   attacked_m;
    int                                   protect_m;
    int                                   n_lines;
    int                                   errors;
    int                                   checks;
    int                                   cycles;
    int                                   limit;
    int                                   total;

    werewolf_top i_werewolf_top (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Run limit scales with the number of test lines
    initial begin
        cycles = 0;
        while (limit == 0 || cycles <= limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout after %0d cycles, the game stopped waiting for input", cycles);
        $display("=== FAIL ===");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic werewolf_pkg::role_t table_role(input int k, input int seat);
        int wolf;
        int rank;
        wolf = k / 4;
        if (seat == wolf) return werewolf_pkg::WOLF;
        rank = (seat > wolf) ? seat - 1 : seat;   // Position among non-wolf seats
        if (rank == k % 4) return werewolf_pkg::MEDIC;
        return werewolf_pkg::VILLAGER;
    endfunction

    function automatic int next_living(input int from);
        int s;
        s = from;
        while (s < werewolf_pkg::NUM_PLAYERS && !alive_m[s]) s++;
        return s;
    endfunction

    function automatic int dead_total();
        int n;
        n = 0;
        for (int i = 0; i < werewolf_pkg::NUM_PLAYERS; i++)
            if (!alive_m[i]) n++;
        return n;
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    task automatic wait_for_input();
        while (!(turn_active || vote_open || wolf_win || village_win)) @(negedge clock);
    endtask

    task automatic press_and_pass(input int code);
        @(posedge clock);
        if (code == 5) skip <= 1'b1;
        else buttons <= 5'b00001 << code;
        @(posedge clock);
        buttons <= '0;
        skip    <= 1'b0;
        repeat (2) @(posedge clock);
        pass <= 1'b1;
        @(posedge clock);
        pass <= 1'b0;
        repeat (2) @(negedge clock);   // Pulse, then the state edge
    endtask

    task automatic start_game(input int wait_cycles);
        @(posedge clock);
        play <= 1'b1;
        @(posedge clock);
        play <= 1'b0;
        repeat (wait_cycles) @(posedge clock);   // Deal counter spins
        pass <= 1'b1;
        @(posedge clock);
        pass <= 1'b0;
        @(negedge clock);
        wait_for_input();
        // Counter also steps on the two edges while the pass pulse forms
        deal_m = (deal_m + wait_cycles + 2) % werewolf_pkg::NUM_DEALS;
        assert (int'(deal_index) == deal_m) else begin
            errors++;
            $display("error deal_index: got %h, expected %h", deal_index, deal_m);
        end
        deal_k     = int'(deal_index);
        alive_m    = '1;
        winner_m   = 2'b00;
        attacked_m = 5;
        protect_m  = 5;
        turn_seat  = 0;
    endtask

    task automatic dawn();
        if (attacked_m != 5 && attacked_m != protect_m) alive_m[attacked_m] = 1'b0;
        if (dead_total() >= werewolf_pkg::WOLF_WIN_DEATHS) winner_m = 2'b01;
    endtask

    task automatic night_move(input int code, input int line);
        werewolf_pkg::role_t role;
        int                  seat;
        logic                legal;
        assert (turn_active) else begin
            errors++;
            $display("line %0d has a night move but no turn is open", line);
        end
        seat = turn_seat;
        role = table_role(deal_k, seat);
        case (role)
            werewolf_pkg::WOLF:  legal = code == 5 || (code < 5 && alive_m[code] && code != seat);
            werewolf_pkg::MEDIC: legal = code == 5 || (code < 5 && alive_m[code]);
            default:             legal = code <= 5;
        endcase
        press_and_pass(code);
        if (!legal) begin
            assert (turn_active && int'(current_player) == seat) else begin
                errors++;
                $display("line %0d closed the turn of seat %0d on an illegal move", line, seat);
            end
        end else begin
            if (role == werewolf_pkg::WOLF) attacked_m = code;
            if (role == werewolf_pkg::MEDIC) protect_m = code;
            turn_seat = next_living(seat + 1);
            if (turn_seat == werewolf_pkg::NUM_PLAYERS) dawn();
            wait_for_input();
        end
    endtask

    task automatic cast_vote(input int code, input int line);
        logic legal;
        assert (vote_open) else begin
            errors++;
            $display("line %0d has a vote but the vote is not open", line);
        end
        legal = code < 5 && alive_m[code];
        press_and_pass(code);
        if (!legal) begin
            assert (vote_open) else begin
                errors++;
                $display("line %0d closed the vote on a dead or missing seat", line);
            end
        end else begin
            if (code == deal_k / 4) begin
                winner_m = 2'b10;            // Wolf found
            end else begin
                alive_m[code] = 1'b0;
                if (dead_total() >= werewolf_pkg::WOLF_WIN_DEATHS) begin
                    winner_m = 2'b01;
                end else begin
                    attacked_m = 5;
                    protect_m  = 5;
                    turn_seat  = next_living(0);
                end
            end
            wait_for_input();
        end
    endtask

    task automatic check_outcome(input logic [7:0] exp_dead, input logic [3:0] exp_win,
                                 input int line);
        checks++;
        assert (exp_dead == {3'b000, ~alive_m} && exp_win == {2'b00, winner_m}) else begin
            errors++;
            $display("line %0d of the test data disagrees with the game rules", line);
        end
        assert (dead_vec == ~alive_m) else begin
            errors++;
            $display("error dead_vec: got %h, expected %h", dead_vec, ~alive_m);
        end
        assert ({village_win, wolf_win} == winner_m) else begin
            errors++;
            $display("error village_win/wolf_win: got %h, expected %h",
                     {village_win, wolf_win}, winner_m);
        end
        if (turn_active) begin
            assert (int'(current_player) == turn_seat) else begin
                errors++;
                $display("error current_player: got %h, expected %h", current_player, turn_seat);
            end
            assert (current_role == table_role(deal_k, turn_seat)) else begin
                errors++;
                $display("error current_role: got %h, expected %h", current_role,
                         table_role(deal_k, turn_seat));
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        reset   = 1'b1;
        play    = 1'b0;
        pass    = 1'b0;
        skip    = 1'b0;
        buttons = '0;
        errors  = 0;
        checks  = 0;
        limit   = 0;
        deal_m  = 0;                     // Counter value out of reset
        $readmemh("bench/werewolf_tests.txt", tests);
        n_lines = 0;
        while (n_lines < 64 && tests[n_lines][19:16] != 4'h0) n_lines++;
        limit = 200 * (n_lines + 1);
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (state == werewolf_pkg::IDLE) else begin
            errors++;
            $display("error state: got %h, expected %h", state, werewolf_pkg::IDLE);
        end
        assert (!turn_active && !vote_open && !wolf_win && !village_win && dead_vec == '0)
            else begin
                errors++;
                $display("a game flag or a dead seat is set after reset");
            end
        for (int i = 0; i < n_lines; i++) begin
            entry = tests[i];
            case (entry[19:16])
                4'h1:    start_game(int'(entry[15:12]));
                4'h2:    night_move(int'(entry[15:12]), i);
                4'h3:    cast_vote(int'(entry[15:12]), i);
                default: begin
                    errors++;
                    $display("line %0d of the test data has an unknown kind", i);
                end
            endcase
            check_outcome(entry[11:4], entry[3:0], i);
        end
        total = errors + i_werewolf_top.i_game_control.i_werewolf_assert.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 i_werewolf_top.i_game_control.i_werewolf_assert.fail_count);
        if (total == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== bench/werewolf_tests.txt ====
// Columns as hex digits K A DD W: K kind (1 deal, 2 night move, 3 vote, 0 end)
// A deal wait cycles or chosen seat code (5 skip), DD dead_vec after it, W winner (1 wolf, 2 village)
18000  // Game one, deal 10
21000
25000
22000  // Wolf picks itself
20000
24000
23010  // Seat 0 dies at dawn
30010  // Vote for a dead seat
31030
24030
20030  // Medic picks a dead seat
24030
25030  // Protected victim lives
32032  // Wolf voted out
14000  // Game two, deal 16
20000
25000
25000
25000
21020
32060
20060
25060
230e1  // Third death
10000  // Game three, deal 18
25000
25000
25000
25000
25000
34002
00000

// ==== all.f ====
hw/werewolf_pkg.sv
hw/button_input.sv
hw/role_deal.sv
hw/player_seat.sv
hw/village_tally.sv
hw/game_control.sv
hw/werewolf_top.sv
bench/werewolf_assert.sv
bench/werewolf_tb.sv

// ==== Makefile ====
TOP = werewolf_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f all.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
